/* filelist.f */
rtl/dispatch_pkg.sv
rtl/fetch_decode.sv
rtl/dispatch_queue.sv
rtl/issue_scoreboard.sv
rtl/dispatch_top.sv
test/tb_dispatch.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dispatch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dispatch \
	-f filelist.f -o sim_dispatch || exit 1
result=$(./obj_dir/sim_dispatch 2>&1)
echo "$result"
echo "$result" | grep -q "^All checks passed$" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* test/dispatch_golden.txt */
# M line_addr line_data | S after_n_issues target_pc | E pc inst rs1 rs2 rd imm halt illegal
# hex except the issue count, a line holds {word at addr+4, word at addr}
M 00000000 FFD0811300500093
M 00000008 00208233123451B7
M 00000010 FFFFF2970041A423
M 00000018 00130463FFC2A303
M 00000020 00100493010003EF
M 00000030 0003846700100493
M 00000038 0050850B006404B3
M 00000080 00A565B380000513
M 00000088 0000001300000073
S 9 00000034
S 12 00000080
E 00000000 00500093 00 00 01 00000005 0 0
E 00000004 FFD08113 01 00 02 FFFFFFFD 0 0
E 00000008 123451B7 00 00 03 12345000 0 0
E 0000000C 00208233 01 02 04 00000000 0 0
E 00000010 0041A423 03 04 00 00000004 0 0
E 00000014 FFFFF297 00 00 05 FFFFF000 0 0
E 00000018 FFC2A303 05 00 06 FFFFFFFC 0 0
E 0000001C 00130463 06 01 00 00000001 0 0
E 00000020 010003EF 00 00 07 00000010 0 0
E 00000034 00038467 07 00 08 00000000 0 0
E 00000038 006404B3 08 06 09 00000000 0 0
E 0000003C 0050850B 01 00 00 00000005 0 1
E 00000080 80000513 00 00 0A FFFFF800 0 0
E 00000084 00A565B3 0A 0A 0B 00000000 0 0
E 00000088 00000073 00 00 00 00000000 1 0

/* test/tb_dispatch.sv */
////////////////////////////////////////
// testbench for the dispatch front end
// golden imem image, writeback and squash model
// checks the in-order issue stream
////////////////////////////////////////

`default_nettype none

module tb_dispatch;

	logic clock;
	logic reset;
	logic [dispatch_pkg::line_bits-1:0] imem_data;
	logic imem_valid;
	logic squash;
	logic [dispatch_pkg::xlen-1:0] squash_pc;
	logic wb_valid;
	logic [dispatch_pkg::reg_idx_bits-1:0] wb_idx;
	logic [dispatch_pkg::xlen-1:0] imem_addr;
	logic issue_valid;
	logic [dispatch_pkg::xlen-1:0] issue_pc;
	logic [dispatch_pkg::xlen-1:0] issue_inst;
	logic [dispatch_pkg::reg_idx_bits-1:0] issue_rs1;
	logic [dispatch_pkg::reg_idx_bits-1:0] issue_rs2;
	logic [dispatch_pkg::reg_idx_bits-1:0] issue_rd;
	logic [dispatch_pkg::xlen-1:0] issue_imm;
	logic issue_halt;
	logic issue_illegal;

	// memory image keyed by line address
	logic [dispatch_pkg::line_bits-1:0] imem [logic [dispatch_pkg::xlen-1:0]];

	// expected issue stream
	logic [dispatch_pkg::xlen-1:0] exp_pc [$];
	dispatch_pkg::rv32_inst_u exp_inst [$];
	logic [dispatch_pkg::reg_idx_bits-1:0] exp_rs1 [$];
	logic [dispatch_pkg::reg_idx_bits-1:0] exp_rs2 [$];
	logic [dispatch_pkg::reg_idx_bits-1:0] exp_rd [$];
	logic [dispatch_pkg::xlen-1:0] exp_imm [$];
	logic exp_halt [$];
	logic exp_illegal [$];

	// squash events as issue count and target
	int sq_after [$];
	logic [dispatch_pkg::xlen-1:0] sq_target [$];

	// writebacks in flight
	logic [dispatch_pkg::reg_idx_bits-1:0] wb_reg_q [$];
	int wb_due_q [$];

	// reference busy bits
	logic [(1 << dispatch_pkg::reg_idx_bits)-1:0] model_busy;
	logic [15:0] lfsr_state;
	int cycle;
	int cycle_limit;
	int issued;
	int sq_idx;
	// cycles since a halt or illegal was the last issue
	int stopped_cycles;
	logic after_squash;
	logic [dispatch_pkg::xlen-1:0] redirect_pc;
	logic extra_issue;
	logic final_halt;

	dispatch_top dut_i (
		.clock(clock),
		.reset(reset),
		.imem_data(imem_data),
		.imem_valid(imem_valid),
		.squash(squash),
		.squash_pc(squash_pc),
		.wb_valid(wb_valid),
		.wb_idx(wb_idx),
		.imem_addr(imem_addr),
		.issue_valid(issue_valid),
		.issue_pc(issue_pc),
		.issue_inst(issue_inst),
		.issue_rs1(issue_rs1),
		.issue_rs2(issue_rs2),
		.issue_rd(issue_rd),
		.issue_imm(issue_imm),
		.issue_halt(issue_halt),
		.issue_illegal(issue_illegal)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	////////////////////////////////////////
	// failure reporting and compares
	////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_addr(input string name, input logic [dispatch_pkg::xlen-1:0] got,
		input logic [dispatch_pkg::xlen-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic compare_inst(input string name, input dispatch_pkg::rv32_inst_u got,
		input dispatch_pkg::rv32_inst_u exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic compare_reg(input string name,
		input logic [dispatch_pkg::reg_idx_bits-1:0] got,
		input logic [dispatch_pkg::reg_idx_bits-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH time=%0t %s got=%0d expected=%0d",
				$time, name, got, exp));
		end
	endtask

	task automatic compare_imm(input string name, input logic [dispatch_pkg::xlen-1:0] got,
		input logic [dispatch_pkg::xlen-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH time=%0t %s got=%b expected=%b",
				$time, name, got, exp));
		end
	endtask

	////////////////////////////////////////
	// random bits and memory model
	////////////////////////////////////////

	// 16 bit fibonacci with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_random_bit(output logic b);
		lfsr_state = lfsr_next(lfsr_state);
		b = lfsr_state[0];
	endtask

	// all-ones opcode is illegal
	// upper bits fold in the whole address
	function automatic logic [dispatch_pkg::xlen-1:0] fill_word(
		input logic [dispatch_pkg::xlen-1:0] a);
		return {a[31:7] ^ {a[6:0], a[31:14]}, 7'h7f};
	endfunction

	function automatic logic [dispatch_pkg::line_bits-1:0] read_line(
		input logic [dispatch_pkg::xlen-1:0] a);
		if (imem.exists(a)) begin
			return imem[a];
		end else begin
			return {fill_word(a + 32'd4), fill_word(a)};
		end
	endfunction

	// line for the current address with valid on a coin flip
	task automatic drive_memory();
		logic coin;
		take_random_bit(coin);
		imem_valid = coin;
		imem_data = read_line(imem_addr);
	endtask

	////////////////////////////////////////
	// golden file
	////////////////////////////////////////

	task automatic load_golden();
		int fd;
		int c;
		int n;
		int f_count;
		logic [dispatch_pkg::xlen-1:0] f_addr;
		logic [dispatch_pkg::line_bits-1:0] f_line;
		logic [dispatch_pkg::xlen-1:0] f_inst;
		logic [dispatch_pkg::xlen-1:0] f_imm;
		logic [dispatch_pkg::reg_idx_bits-1:0] f_rs1;
		logic [dispatch_pkg::reg_idx_bits-1:0] f_rs2;
		logic [dispatch_pkg::reg_idx_bits-1:0] f_rd;
		logic f_halt;
		logic f_illegal;
		fd = $fopen("test/dispatch_golden.txt", "r");
		if (fd == 0) begin
			fail_run("could not open test/dispatch_golden.txt");
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				// comment runs to end of line
				while (c != "\n" && c != -1) begin
					c = $fgetc(fd);
				end
			end else if (c == "M") begin
				n = $fscanf(fd, " %h %h", f_addr, f_line);
				if (n != 2) begin
					fail_run("malformed memory record in golden file");
				end
				imem[f_addr] = f_line;
			end else if (c == "S") begin
				n = $fscanf(fd, " %d %h", f_count, f_addr);
				if (n != 2) begin
					fail_run("malformed squash record in golden file");
				end
				sq_after.push_back(f_count);
				sq_target.push_back(f_addr);
			end else if (c == "E") begin
				n = $fscanf(fd, " %h %h %h %h %h %h %h %h", f_addr, f_inst, f_rs1, f_rs2,
					f_rd, f_imm, f_halt, f_illegal);
				if (n != 8) begin
					fail_run("malformed expected-issue record in golden file");
				end
				exp_pc.push_back(f_addr);
				exp_inst.push_back(f_inst);
				exp_rs1.push_back(f_rs1);
				exp_rs2.push_back(f_rs2);
				exp_rd.push_back(f_rd);
				exp_imm.push_back(f_imm);
				exp_halt.push_back(f_halt);
				exp_illegal.push_back(f_illegal);
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////
	// per-cycle model
	////////////////////////////////////////

	// issue seen now was popped last cycle and model_busy still holds the pop-time state
	task automatic check_issue();
		int idx;
		logic b0;
		logic b1;
		idx = issued;
		if (after_squash) begin
			compare_addr("issue_pc after squash", issue_pc, redirect_pc);
			after_squash = 1'b0;
		end
		compare_addr("issue_pc", issue_pc, exp_pc[idx]);
		compare_inst("issue_inst", issue_inst, exp_inst[idx]);
		compare_reg("issue_rs1", issue_rs1, exp_rs1[idx]);
		compare_reg("issue_rs2", issue_rs2, exp_rs2[idx]);
		compare_reg("issue_rd", issue_rd, exp_rd[idx]);
		compare_imm("issue_imm", issue_imm, exp_imm[idx]);
		compare_flag("issue_halt", issue_halt, exp_halt[idx]);
		compare_flag("issue_illegal", issue_illegal, exp_illegal[idx]);
		// unused sources come out as x0 which is never busy
		if (model_busy[issue_rs1] || model_busy[issue_rs2]) begin
			fail_run($sformatf("pc %h issued before its source was written back", issue_pc));
		end
		if (issue_rd != dispatch_pkg::zero_reg) begin
			// result returns 1 to 4 cycles later
			take_random_bit(b0);
			take_random_bit(b1);
			wb_reg_q.push_back(issue_rd);
			wb_due_q.push_back(cycle + 1 + int'({b1, b0}));
		end
		issued++;
	endtask

	// replay the edge just passed
	// squash clears everything
	// otherwise wb clears before issue sets
	task automatic update_busy_model();
		if (squash) begin
			model_busy = '0;
		end else begin
			if (wb_valid) begin
				model_busy[wb_idx] = 1'b0;
			end
			if (issue_valid && issue_rd != dispatch_pkg::zero_reg) begin
				model_busy[issue_rd] = 1'b1;
			end
		end
	endtask

	// after a halt or illegal the squash waits while fetch must stay stopped
	task automatic drive_squash();
		logic stop_seen;
		squash = 1'b0;
		stop_seen = issued > 0 && (exp_halt[issued-1] || exp_illegal[issued-1]);
		if (stop_seen) begin
			stopped_cycles++;
		end else begin
			stopped_cycles = 0;
		end
		if (sq_idx < sq_after.size() && issued == sq_after[sq_idx]
			&& (!stop_seen || stopped_cycles > 8)) begin
			squash = 1'b1;
			squash_pc = sq_target[sq_idx];
			redirect_pc = sq_target[sq_idx];
			after_squash = 1'b1;
			sq_idx++;
			// in-flight results die with the squash
			wb_reg_q.delete();
			wb_due_q.delete();
		end
	endtask

	// single port with the oldest due entry first
	task automatic drive_writeback();
		int i;
		logic found;
		wb_valid = 1'b0;
		wb_idx = '0;
		found = 1'b0;
		i = 0;
		while (!squash && !found && i < wb_due_q.size()) begin
			if (wb_due_q[i] <= cycle) begin
				wb_valid = 1'b1;
				wb_idx = wb_reg_q[i];
				wb_reg_q.delete(i);
				wb_due_q.delete(i);
				found = 1'b1;
			end else begin
				i++;
			end
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		imem_data = '0;
		imem_valid = 1'b0;
		squash = 1'b0;
		squash_pc = '0;
		wb_valid = 1'b0;
		wb_idx = '0;
		lfsr_state = 16'd47;
		model_busy = '0;
		cycle = 0;
		issued = 0;
		sq_idx = 0;
		stopped_cycles = 0;
		after_squash = 1'b0;
		redirect_pc = '0;
		extra_issue = 1'b0;
		final_halt = 1'b0;
		load_golden();
		cycle_limit = 40 * exp_pc.size();

		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;
		// fetch starts at zero with nothing issued
		compare_addr("imem_addr", imem_addr, '0);
		compare_flag("issue_valid", issue_valid, 1'b0);
		drive_memory();

		// inputs change 2 units after each rising edge
		while (issued < exp_pc.size()) begin
			@(posedge clock);
			#2;
			cycle++;
			if (cycle > cycle_limit) begin
				fail_run($sformatf("timeout after %0d cycles, %0d of %0d instructions issued",
					cycle_limit, issued, exp_pc.size()));
			end
			if (issue_valid) begin
				check_issue();
			end
			update_busy_model();
			drive_squash();
			drive_writeback();
			drive_memory();
		end
		final_halt = issue_halt;

		// fetch is halted so nothing more may issue
		squash = 1'b0;
		wb_valid = 1'b0;
		repeat (8) begin
			@(posedge clock);
			#2;
			if (issue_valid) begin
				extra_issue = 1'b1;
			end
			drive_memory();
		end

		if (final_halt && !extra_issue && sq_idx == sq_after.size()) begin
			$display("All checks passed");
			$finish;
		end else begin
			fail_run("run did not end on a final halt with every squash applied");
		end
	end

endmodule

`default_nettype wire

/* rtl/dispatch_top.sv */
////////////////////////////////////////
// front end top level
// fetch/decode -> dispatch queue -> issue
////////////////////////////////////////

`default_nettype none

module dispatch_top (
	input  logic clock,
	input  logic reset,
	input  logic [dispatch_pkg::line_bits-1:0] imem_data,
	input  logic imem_valid,
	input  logic squash,
	input  logic [dispatch_pkg::xlen-1:0] squash_pc,
	input  logic wb_valid,
	input  logic [dispatch_pkg::reg_idx_bits-1:0] wb_idx,
	output logic [dispatch_pkg::xlen-1:0] imem_addr,
	output logic issue_valid,
	output logic [dispatch_pkg::xlen-1:0] issue_pc,
	output logic [dispatch_pkg::xlen-1:0] issue_inst,
	output logic [dispatch_pkg::reg_idx_bits-1:0] issue_rs1,
	output logic [dispatch_pkg::reg_idx_bits-1:0] issue_rs2,
	output logic [dispatch_pkg::reg_idx_bits-1:0] issue_rd,
	output logic [dispatch_pkg::xlen-1:0] issue_imm,
	output logic issue_halt,
	output logic issue_illegal
);

	// decode to queue
	logic queue_full;
	logic dec_valid;
	logic [dispatch_pkg::xlen-1:0] dec_pc;
	logic [dispatch_pkg::xlen-1:0] dec_inst;
	logic [dispatch_pkg::reg_idx_bits-1:0] dec_rs1;
	logic dec_need_rs1;
	logic [dispatch_pkg::reg_idx_bits-1:0] dec_rs2;
	logic dec_need_rs2;
	logic [dispatch_pkg::reg_idx_bits-1:0] dec_rd;
	logic [dispatch_pkg::xlen-1:0] dec_imm;
	logic dec_halt;
	logic dec_illegal;

	// queue head to issue
	logic head_valid;
	logic head_pop;
	logic [dispatch_pkg::xlen-1:0] head_pc;
	logic [dispatch_pkg::xlen-1:0] head_inst;
	logic [dispatch_pkg::reg_idx_bits-1:0] head_rs1;
	logic head_need_rs1;
	logic [dispatch_pkg::reg_idx_bits-1:0] head_rs2;
	logic head_need_rs2;
	logic [dispatch_pkg::reg_idx_bits-1:0] head_rd;
	logic [dispatch_pkg::xlen-1:0] head_imm;
	logic head_halt;
	logic head_illegal;

	fetch_decode fetch_decode_i (
		.clock(clock),
		.reset(reset),
		.imem_data(imem_data),
		.imem_valid(imem_valid),
		.queue_full(queue_full),
		.squash(squash),
		.squash_pc(squash_pc),
		.imem_addr(imem_addr),
		.dec_valid(dec_valid),
		.dec_pc(dec_pc),
		.dec_inst(dec_inst),
		.dec_rs1(dec_rs1),
		.dec_need_rs1(dec_need_rs1),
		.dec_rs2(dec_rs2),
		.dec_need_rs2(dec_need_rs2),
		.dec_rd(dec_rd),
		.dec_imm(dec_imm),
		.dec_halt(dec_halt),
		.dec_illegal(dec_illegal)
	);

	// squash also flushes everything still waiting
	dispatch_queue dispatch_queue_i (
		.clock(clock),
		.reset(reset),
		.push(dec_valid),
		.push_pc(dec_pc),
		.push_inst(dec_inst),
		.push_rs1(dec_rs1),
		.push_need_rs1(dec_need_rs1),
		.push_rs2(dec_rs2),
		.push_need_rs2(dec_need_rs2),
		.push_rd(dec_rd),
		.push_imm(dec_imm),
		.push_halt(dec_halt),
		.push_illegal(dec_illegal),
		.pop(head_pop),
		.flush(squash),
		.full(queue_full),
		.head_valid(head_valid),
		.head_pc(head_pc),
		.head_inst(head_inst),
		.head_rs1(head_rs1),
		.head_need_rs1(head_need_rs1),
		.head_rs2(head_rs2),
		.head_need_rs2(head_need_rs2),
		.head_rd(head_rd),
		.head_imm(head_imm),
		.head_halt(head_halt),
		.head_illegal(head_illegal)
	);

	issue_scoreboard issue_scoreboard_i (
		.clock(clock),
		.reset(reset),
		.head_valid(head_valid),
		.head_pc(head_pc),
		.head_inst(head_inst),
		.head_rs1(head_rs1),
		.head_need_rs1(head_need_rs1),
		.head_rs2(head_rs2),
		.head_need_rs2(head_need_rs2),
		.head_rd(head_rd),
		.head_imm(head_imm),
		.head_halt(head_halt),
		.head_illegal(head_illegal),
		.squash(squash),
		.wb_valid(wb_valid),
		.wb_idx(wb_idx),
		.head_pop(head_pop),
		.issue_valid(issue_valid),
		.issue_pc(issue_pc),
		.issue_inst(issue_inst),
		.issue_rs1(issue_rs1),
		.issue_rs2(issue_rs2),
		.issue_rd(issue_rd),
		.issue_imm(issue_imm),
		.issue_halt(issue_halt),
		.issue_illegal(issue_illegal)
	);

endmodule

`default_nettype wire

/* rtl/issue_scoreboard.sv */
////////////////////////////////////////
// in-order issue with busy scoreboard
// 32 busy bits, set on issue, cleared on wb
////////////////////////////////////////

`default_nettype none

module issue_scoreboard (
	input  logic clock,
	input  logic reset,
	input  logic head_valid,
	input  logic [dispatch_pkg::xlen-1:0] head_pc,
	input  logic [dispatch_pkg::xlen-1:0] head_inst,
	input  logic [dispatch_pkg::reg_idx_bits-1:0] head_rs1,
	input  logic head_need_rs1,
	input  logic [dispatch_pkg::reg_idx_bits-1:0] head_rs2,
	input  logic head_need_rs2,
	input  logic [dispatch_pkg::reg_idx_bits-1:0] head_rd,
	input  logic [dispatch_pkg::xlen-1:0] head_imm,
	input  logic head_halt,
	input  logic head_illegal,
	input  logic squash,
	input  logic wb_valid,
	input  logic [dispatch_pkg::reg_idx_bits-1:0] wb_idx,
	output logic head_pop,
	output logic issue_valid,
	output logic [dispatch_pkg::xlen-1:0] issue_pc,
	output logic [dispatch_pkg::xlen-1:0] issue_inst,
	output logic [dispatch_pkg::reg_idx_bits-1:0] issue_rs1,
	output logic [dispatch_pkg::reg_idx_bits-1:0] issue_rs2,
	output logic [dispatch_pkg::reg_idx_bits-1:0] issue_rd,
	output logic [dispatch_pkg::xlen-1:0] issue_imm,
	output logic issue_halt,
	output logic issue_illegal
);

	// one bit per architectural register
	logic [(1 << dispatch_pkg::reg_idx_bits)-1:0] busy;
	logic rs1_busy;
	logic rs2_busy;

	////////////////////////////////////////
	// issue check
	////////////////////////////////////////

	// unused sources never block
	assign rs1_busy = head_need_rs1 && busy[head_rs1];
	assign rs2_busy = head_need_rs2 && busy[head_rs2];

	// head leaves the queue the cycle it issues
	assign head_pop = head_valid && !rs1_busy && !rs2_busy && !squash;

	////////////////////////////////////////
	// scoreboard update
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			busy <= '0;
		end else begin
			// clear first so a same cycle issue keeps rd busy
			if (wb_valid) begin
				busy[wb_idx] <= 1'b0;
			end
			if (head_pop && head_rd != dispatch_pkg::zero_reg) begin
				busy[head_rd] <= 1'b1;
			end
		end
	end

	// issue valid lands one cycle after the pop edge
	always_ff @(posedge clock) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= head_pop;
		end
	end

	// issued instruction payload
	always_ff @(posedge clock) begin
		if (head_pop) begin
			issue_pc <= head_pc;
			issue_inst <= head_inst;
			issue_rs1 <= head_rs1;
			issue_rs2 <= head_rs2;
			issue_rd <= head_rd;
			issue_imm <= head_imm;
			issue_halt <= head_halt;
			issue_illegal <= head_illegal;
		end
	end

	// popped sources are free
	// unused ones arrive as x0 which is never busy
	assert property (@(posedge clock) disable iff (reset)
		head_pop |-> (!busy[head_rs1] && !busy[head_rs2]));

endmodule

`default_nettype wire

/* rtl/dispatch_queue.sv */
////////////////////////////////////////
// dispatch queue
// circular FIFO of decoded instructions
////////////////////////////////////////

`default_nettype none

module dispatch_queue (
	input  logic clock,
	input  logic reset,
	input  logic push,
	input  logic [dispatch_pkg::xlen-1:0] push_pc,
	input  logic [dispatch_pkg::xlen-1:0] push_inst,
	input  logic [dispatch_pkg::reg_idx_bits-1:0] push_rs1,
	input  logic push_need_rs1,
	input  logic [dispatch_pkg::reg_idx_bits-1:0] push_rs2,
	input  logic push_need_rs2,
	input  logic [dispatch_pkg::reg_idx_bits-1:0] push_rd,
	input  logic [dispatch_pkg::xlen-1:0] push_imm,
	input  logic push_halt,
	input  logic push_illegal,
	input  logic pop,
	input  logic flush,
	output logic full,
	output logic head_valid,
	output logic [dispatch_pkg::xlen-1:0] head_pc,
	output logic [dispatch_pkg::xlen-1:0] head_inst,
	output logic [dispatch_pkg::reg_idx_bits-1:0] head_rs1,
	output logic head_need_rs1,
	output logic [dispatch_pkg::reg_idx_bits-1:0] head_rs2,
	output logic head_need_rs2,
	output logic [dispatch_pkg::reg_idx_bits-1:0] head_rd,
	output logic [dispatch_pkg::xlen-1:0] head_imm,
	output logic head_halt,
	output logic head_illegal
);

	// entry storage, one array per field
	logic [dispatch_pkg::xlen-1:0] pc_mem [dispatch_pkg::queue_depth];
	logic [dispatch_pkg::xlen-1:0] inst_mem [dispatch_pkg::queue_depth];
	logic [dispatch_pkg::reg_idx_bits-1:0] rs1_mem [dispatch_pkg::queue_depth];
	logic need_rs1_mem [dispatch_pkg::queue_depth];
	logic [dispatch_pkg::reg_idx_bits-1:0] rs2_mem [dispatch_pkg::queue_depth];
	logic need_rs2_mem [dispatch_pkg::queue_depth];
	logic [dispatch_pkg::reg_idx_bits-1:0] rd_mem [dispatch_pkg::queue_depth];
	logic [dispatch_pkg::xlen-1:0] imm_mem [dispatch_pkg::queue_depth];
	logic halt_mem [dispatch_pkg::queue_depth];
	logic illegal_mem [dispatch_pkg::queue_depth];

	// pointers wrap naturally at the power of two depth
	logic [dispatch_pkg::queue_ptr_bits-1:0] rd_ptr;
	logic [dispatch_pkg::queue_ptr_bits-1:0] wr_ptr;
	// one extra bit to tell full from empty
	logic [dispatch_pkg::queue_ptr_bits:0] count;

	assign full = count == (dispatch_pkg::queue_ptr_bits+1)'(dispatch_pkg::queue_depth);
	assign head_valid = count != '0;

	// write port
	always_ff @(posedge clock) begin
		if (push) begin
			pc_mem[wr_ptr] <= push_pc;
			inst_mem[wr_ptr] <= push_inst;
			rs1_mem[wr_ptr] <= push_rs1;
			need_rs1_mem[wr_ptr] <= push_need_rs1;
			rs2_mem[wr_ptr] <= push_rs2;
			need_rs2_mem[wr_ptr] <= push_need_rs2;
			rd_mem[wr_ptr] <= push_rd;
			imm_mem[wr_ptr] <= push_imm;
			halt_mem[wr_ptr] <= push_halt;
			illegal_mem[wr_ptr] <= push_illegal;
		end
	end

	// pointers and occupancy, flush empties the queue
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// head read port
	assign head_pc = pc_mem[rd_ptr];
	assign head_inst = inst_mem[rd_ptr];
	assign head_rs1 = rs1_mem[rd_ptr];
	assign head_need_rs1 = need_rs1_mem[rd_ptr];
	assign head_rs2 = rs2_mem[rd_ptr];
	assign head_need_rs2 = need_rs2_mem[rd_ptr];
	assign head_rd = rd_mem[rd_ptr];
	assign head_imm = imm_mem[rd_ptr];
	assign head_halt = halt_mem[rd_ptr];
	assign head_illegal = illegal_mem[rd_ptr];

	// producer and consumer must respect the levels
	assert property (@(posedge clock) disable iff (reset) push |-> !full);
	assert property (@(posedge clock) disable iff (reset) pop |-> head_valid);

endmodule

`default_nettype wire

/* rtl/fetch_decode.sv */
////////////////////////////////////////
// fetch and decode stage
// program counter, line half select,
// rv32i decoder, halt stop and redirect
////////////////////////////////////////

`default_nettype none

module fetch_decode (
	input  logic clock,
	input  logic reset,
	input  logic [dispatch_pkg::line_bits-1:0] imem_data,
	input  logic imem_valid,
	input  logic queue_full,
	input  logic squash,
	input  logic [dispatch_pkg::xlen-1:0] squash_pc,
	output logic [dispatch_pkg::xlen-1:0] imem_addr,
	output logic dec_valid,
	output logic [dispatch_pkg::xlen-1:0] dec_pc,
	output logic [dispatch_pkg::xlen-1:0] dec_inst,
	output logic [dispatch_pkg::reg_idx_bits-1:0] dec_rs1,
	output logic dec_need_rs1,
	output logic [dispatch_pkg::reg_idx_bits-1:0] dec_rs2,
	output logic dec_need_rs2,
	output logic [dispatch_pkg::reg_idx_bits-1:0] dec_rd,
	output logic [dispatch_pkg::xlen-1:0] dec_imm,
	output logic dec_halt,
	output logic dec_illegal
);

	// pc of the instruction being fetched
	logic [dispatch_pkg::xlen-1:0] pc;
	// set once a halt or illegal has been queued
	logic halted;

	dispatch_pkg::rv32_inst_u inst_word;
	logic [6:0] opcode;

	// opcode classes
	logic is_lui;
	logic is_auipc;
	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_load;
	logic is_store;
	logic is_imm;
	logic is_reg;
	logic writes_rd;

	logic [dispatch_pkg::xlen-1:0] imm_i;
	logic [dispatch_pkg::xlen-1:0] imm_u;

	////////////////////////////////////////
	// fetch
	////////////////////////////////////////

	// memory is addressed by line
	assign imem_addr = {pc[dispatch_pkg::xlen-1:3], 3'b000};

	// pc[2] picks the upper word of the line
	assign inst_word = pc[2] ? imem_data[dispatch_pkg::line_bits-1:dispatch_pkg::xlen]
		: imem_data[dispatch_pkg::xlen-1:0];

	// nothing is produced while halted, full or squashing
	assign dec_valid = imem_valid && !queue_full && !halted && !squash;

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	assign opcode = inst_word.i_fmt.opcode;

	assign is_lui = opcode == dispatch_pkg::op_lui;
	assign is_auipc = opcode == dispatch_pkg::op_auipc;
	assign is_jal = opcode == dispatch_pkg::op_jal;
	assign is_jalr = opcode == dispatch_pkg::op_jalr;
	assign is_branch = opcode == dispatch_pkg::op_branch;
	assign is_load = opcode == dispatch_pkg::op_load;
	assign is_store = opcode == dispatch_pkg::op_store;
	assign is_imm = opcode == dispatch_pkg::op_imm;
	assign is_reg = opcode == dispatch_pkg::op_reg;

	// only the exact ecall word is a halt
	// other system ops fall out as illegal
	assign dec_halt = (opcode == dispatch_pkg::op_system)
		&& (inst_word == dispatch_pkg::inst_halt);
	assign dec_illegal = !(is_lui || is_auipc || is_jal || is_jalr || is_branch
		|| is_load || is_store || is_imm || is_reg || dec_halt);

	// source requests with the index forced to x0 when unused
	assign dec_need_rs1 = !(is_lui || is_auipc || is_jal || dec_halt);
	assign dec_rs1 = dec_need_rs1 ? inst_word.i_fmt.rs1 : dispatch_pkg::zero_reg;
	assign dec_need_rs2 = is_reg || is_store || is_branch;
	assign dec_rs2 = dec_need_rs2 ? inst_word.r_fmt.rs2 : dispatch_pkg::zero_reg;

	// destination
	assign writes_rd = is_reg || is_imm || is_load || is_lui || is_auipc || is_jal || is_jalr;
	assign dec_rd = writes_rd ? inst_word.i_fmt.rd : dispatch_pkg::zero_reg;

	// immediates from both views of the word
	assign imm_i = {{(dispatch_pkg::xlen-12){inst_word.i_fmt.imm12[11]}}, inst_word.i_fmt.imm12};
	assign imm_u = {inst_word.u_fmt.imm20, 12'b0};

	always_comb begin
		if (is_lui || is_auipc) begin
			dec_imm = imm_u;
		end else if (is_reg) begin
			dec_imm = '0;
		end else begin
			// sign extended i view for everything else
			dec_imm = imm_i;
		end
	end

	assign dec_pc = pc;
	assign dec_inst = inst_word;

	////////////////////////////////////////
	// pc and halt state
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (squash) begin
			// redirect wins over everything
			pc <= squash_pc;
			halted <= 1'b0;
		end else if (dec_valid) begin
			pc <= pc + {{(dispatch_pkg::xlen-3){1'b0}}, 3'd4};
			if (dec_halt || dec_illegal) begin
				halted <= 1'b1;
			end
		end
	end

	// squash targets keep the pc word aligned
	assert property (@(posedge clock) disable iff (reset)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/dispatch_pkg.sv */
////////////////////////////////////////
// shared widths and sizes for the front end
// rv32i opcode constants and halt encoding
// instruction word union (i / u / r views)
////////////////////////////////////////

`default_nettype none

package dispatch_pkg;

	////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////

	// address and data width
	localparam int xlen = 32;
	// one imem line holds two instructions
	localparam int line_bits = 64;
	localparam int reg_idx_bits = 5;

	// dispatch queue geometry, depth is a power of two
	localparam int queue_depth = 4;
	localparam int queue_ptr_bits = 2;

	// x0 is hardwired, never tracked as busy
	localparam logic [reg_idx_bits-1:0] zero_reg = 5'd0;

	////////////////////////////////////////
	// rv32i major opcodes
	////////////////////////////////////////

	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	// ecall, used as the halt marker
	localparam logic [xlen-1:0] inst_halt = 32'h0000_0073;

	// one instruction word, read through whichever view fits the opcode
	typedef union packed {
		struct packed {
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i_fmt;
		struct packed {
			logic [19:0] imm20;
			logic [4:0] rd;
			logic [6:0] opcode;
		} u_fmt;
		// rs2 overlays the low five bits of imm12
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
	} rv32_inst_u;

endpackage

`default_nettype wire
